// ==== Bender.yml ====
package:
  name: pic_control

sources:
  - files:
      - verilog/pic_cmd_pkg.sv
      - verilog/pic_seq_pkg.sv
      - verilog/pic_init_ctrl.sv
      - verilog/pic_inta_seq.sv
      - verilog/pic_ocw_ctrl.sv
      - verilog/pic_control_top.sv
  - target: test
    files:
      - verification/pic_control_chk.sv
      - verification/pic_control_monitor.sv
      - verification/pic_control_tb.sv

// ==== pic_control_top.f ====
verilog/pic_cmd_pkg.sv
verilog/pic_seq_pkg.sv
verilog/pic_init_ctrl.sv
verilog/pic_inta_seq.sv
verilog/pic_ocw_ctrl.sv
verilog/pic_control_top.sv
verification/pic_control_chk.sv
verification/pic_control_monitor.sv
verification/pic_control_tb.sv

// ==== verification/pic_control_chk.sv ====
// PIC control assertions
`timescale 1ns/1ps
`default_nettype none

module pic_control_chk (
  input logic       clk,
  input logic       rst_n,
  input logic       set_isr,
  input logic       ack_done,
  input logic       vector_valid,
  input logic       init_done,
  input logic [7:0] eoi
);

  int fail_count = 0;

  set_isr_single: assert property (@(posedge clk) disable iff (!rst_n) set_isr |=> !set_isr)
    else begin
      fail_count++;
      $error("set_isr stayed high for more than one cycle");
    end

  ack_done_single: assert property (@(posedge clk) disable iff (!rst_n) ack_done |=> !ack_done)
    else begin
      fail_count++;
      $error("ack_done stayed high for more than one cycle");
    end

  // vector only once the core is configured
  vector_needs_init: assert property (@(posedge clk) disable iff (!rst_n)
    !(vector_valid && !init_done))
    else begin
      fail_count++;
      $error("vector_valid high while init_done is low");
    end

  eoi_single: assert property (@(posedge clk) disable iff (!rst_n) (eoi != '0) |=> (eoi == '0))
    else begin
      fail_count++;
      $error("eoi nonzero for more than one cycle");
    end

endmodule

bind pic_control_top pic_control_chk chk_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .set_isr      (set_isr),
  .ack_done     (ack_done),
  .vector_valid (vector_valid),
  .init_done    (init_done),
  .eoi          (eoi)
);

`default_nettype wire

// ==== verification/pic_control_monitor.sv ====
// PIC control response monitor
`timescale 1ns/1ps
`default_nettype none

module pic_control_monitor #(
  parameter int PULSE_WAIT = 50
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mark,
  input  logic       exp_req,
  input  logic [3:0] exp_sig,
  input  logic [7:0] exp_val,
  input  logic       int_req,
  input  logic       set_isr,
  input  logic [7:0] clear_irr,
  input  logic [7:0] eoi,
  input  logic [7:0] vector,
  input  logic       vector_valid,
  input  logic       ltim,
  input  logic       read_req,
  input  logic       read_isr,
  input  logic       init_done,
  output logic       exp_done,
  output int         tests,
  output int         errors
);

  logic       seen_isr;
  logic       seen_vec;
  logic       seen_eoi;
  logic [7:0] cap_irr;
  logic [7:0] cap_vec;
  logic [7:0] cap_eoi;

  // latest pulse values, forgotten when a new operation starts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_isr <= 1'b0;
      seen_vec <= 1'b0;
      seen_eoi <= 1'b0;
      cap_irr  <= '0;
      cap_vec  <= '0;
      cap_eoi  <= '0;
    end else if (mark) begin
      seen_isr <= 1'b0;
      seen_vec <= 1'b0;
      seen_eoi <= 1'b0;
    end else begin
      if (set_isr) begin
        seen_isr <= 1'b1;
        cap_irr  <= clear_irr;
      end
      if (vector_valid) begin
        seen_vec <= 1'b1;
        cap_vec  <= vector;
      end
      if (eoi != '0) begin
        seen_eoi <= 1'b1;
        cap_eoi  <= eoi;
      end
    end
  end

  function automatic string sig_name(input logic [3:0] sig);
    case (sig)
      4'd0: return "int_req";
      4'd1: return "init_done";
      4'd2: return "ltim";
      4'd3: return "read_req";
      4'd4: return "read_isr";
      4'd5: return "clear_irr";
      4'd6: return "vector";
      4'd7: return "eoi";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic is_pulse(input logic [3:0] sig);
    return (sig >= 4'd5) && (sig <= 4'd7);
  endfunction

  function automatic logic pulse_seen(input logic [3:0] sig);
    case (sig)
      4'd5: return seen_isr;
      4'd6: return seen_vec;
      default: return seen_eoi;
    endcase
  endfunction

  function automatic logic [7:0] sample(input logic [3:0] sig);
    case (sig)
      4'd0: return {7'b0, int_req};
      4'd1: return {7'b0, init_done};
      4'd2: return {7'b0, ltim};
      4'd3: return {7'b0, read_req};
      4'd4: return {7'b0, read_isr};
      4'd5: return cap_irr;
      4'd6: return cap_vec;
      4'd7: return cap_eoi;
      default: return 8'hxx;
    endcase
  endfunction

  task automatic run_check(input logic [3:0] sig, input logic [7:0] val);
    logic [7:0] actual;
    int         waited;
    waited = 0;
    // pulses may still be on their way through the synchronizer
    while (is_pulse(sig) && !pulse_seen(sig) && waited < PULSE_WAIT) begin
      @(posedge clk);
      waited++;
    end
    actual = sample(sig);
    tests++;
    if (is_pulse(sig) && !pulse_seen(sig)) begin
      errors++;
      $display("test %0d: no %s pulse arrived within %0d cycles", tests, sig_name(sig),
               PULSE_WAIT);
    end else if (actual !== val) begin
      errors++;
      $display("error at %0t: %s expected %h, actual %h", $time, sig_name(sig), val, actual);
    end else begin
      $display("test %0d: %s = %h ok", tests, sig_name(sig), actual);
    end
  endtask

  initial begin
    exp_done = 1'b0;
    tests    = 0;
    errors   = 0;
    forever begin
      @(posedge clk);
      if (exp_req && !exp_done) begin
        run_check(exp_sig, exp_val);
        exp_done <= 1'b1;
      end else begin
        exp_done <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/pic_control_stimulus.txt ====
# op arg1 arg2, all hex: W a0 data = write, I irq isr = request inputs
# A 0 0 = INTA pulse pair, E name value = expected value of a DUT output
W 0 1b
E eoi ff
E init_done 0
W 1 40
E init_done 0
W 1 00
E init_done 1
E ltim 1
# a0 high write in READY is OCW1
W 1 ff
E init_done 1
I 10 00
E int_req 1
A 0 0
E clear_irr 10
E vector 44
W 0 65
E eoi 20
I 10 08
W 0 20
E eoi 08
W 0 0b
E read_req 1
E read_isr 1
W 0 0a
E read_isr 0
E read_req 1
# re-init with cascade byte and AEOI
W 0 11
E eoi ff
E init_done 0
E int_req 0
E read_req 0
W 1 40
W 1 00
E init_done 0
W 1 02
E init_done 1
E ltim 0
I 04 00
A 0 0
E clear_irr 04
E vector 42
E eoi 04

// ==== verification/pic_control_tb.sv ====
// PIC control core testbench
`timescale 1ns/1ps
`default_nettype none

module pic_control_tb;

  localparam time CLK_PERIOD = 40ns;
  localparam int  MAX_OPS    = 256;
  localparam int  INTA_WIDTH = 6;

  logic       clk;
  logic       rst_n;
  logic       wr;
  logic       a0;
  logic [7:0] din;
  logic       inta_n;
  logic [7:0] irq_highest;
  logic [7:0] isr_highest;
  logic       int_req;
  logic       set_isr;
  logic [7:0] clear_irr;
  logic [7:0] eoi;
  logic [7:0] vector;
  logic       vector_valid;
  logic       ltim;
  logic       read_req;
  logic       read_isr;
  logic       init_done;

  logic       mark;
  logic       exp_req;
  logic [3:0] exp_sig;
  logic [7:0] exp_val;
  logic       exp_done;
  int         tests;
  int         errors;

  logic [7:0] op_kind [MAX_OPS];
  logic [7:0] op_a [MAX_OPS];
  logic [7:0] op_b [MAX_OPS];
  int         n_ops;
  logic       loaded;
  int         total;
  int         bad_ops;

  pic_control_top #(
    .SYNC_STAGES (2)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr           (wr),
    .a0           (a0),
    .din          (din),
    .inta_n       (inta_n),
    .irq_highest  (irq_highest),
    .isr_highest  (isr_highest),
    .int_req      (int_req),
    .set_isr      (set_isr),
    .clear_irr    (clear_irr),
    .eoi          (eoi),
    .vector       (vector),
    .vector_valid (vector_valid),
    .ltim         (ltim),
    .read_req     (read_req),
    .read_isr     (read_isr),
    .init_done    (init_done)
  );

  pic_control_monitor mon_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mark         (mark),
    .exp_req      (exp_req),
    .exp_sig      (exp_sig),
    .exp_val      (exp_val),
    .int_req      (int_req),
    .set_isr      (set_isr),
    .clear_irr    (clear_irr),
    .eoi          (eoi),
    .vector       (vector),
    .vector_valid (vector_valid),
    .ltim         (ltim),
    .read_req     (read_req),
    .read_isr     (read_isr),
    .init_done    (init_done),
    .exp_done     (exp_done),
    .tests        (tests),
    .errors       (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // inputs move 2 ns after the rising edge
  task automatic after_edge;
    @(posedge clk);
    #2;
  endtask

  function automatic logic [3:0] signal_code(input logic [8*16-1:0] name);
    case (name)
      "int_req":   return 4'd0;
      "init_done": return 4'd1;
      "ltim":      return 4'd2;
      "read_req":  return 4'd3;
      "read_isr":  return 4'd4;
      "clear_irr": return 4'd5;
      "vector":    return 4'd6;
      "eoi":       return 4'd7;
      default:     return 4'd15;
    endcase
  endfunction

  task automatic load_stimulus;
    int              fd;
    int              cnt;
    logic [8*80-1:0] line;
    logic [8*16-1:0] op;
    logic [8*16-1:0] name;
    logic [7:0]      a;
    logic [7:0]      b;
    n_ops = 0;
    fd = $fopen("verification/pic_control_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_ops < MAX_OPS) begin
        line = '0;
        op   = '0;
        a    = '0;
        b    = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%s", op);
        // skip blank and comment lines
        if (cnt == 1 && op != "#") begin
          if (op == "E") begin
            cnt = $sscanf(line, "%s %s %h", op, name, b);
            a   = {4'h0, signal_code(name)};
          end else begin
            cnt = $sscanf(line, "%s %h %h", op, a, b);
          end
          op_kind[n_ops] = op[7:0];
          op_a[n_ops]    = a;
          op_b[n_ops]    = b;
          n_ops++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic write_reg(input logic addr, input logic [7:0] data);
    after_edge();
    wr   = 1'b1;
    a0   = addr;
    din  = data;
    mark = 1'b1;
    after_edge();
    wr   = 1'b0;
    mark = 1'b0;
  endtask

  task automatic inta_pair;
    after_edge();
    mark = 1'b1;
    after_edge();
    mark = 1'b0;
    repeat (2) begin
      inta_n = 1'b0;
      repeat (INTA_WIDTH) after_edge();
      inta_n = 1'b1;
      repeat (INTA_WIDTH) after_edge();
    end
  endtask

  task automatic expect_value(input logic [3:0] sig, input logic [7:0] val);
    after_edge();
    exp_sig = sig;
    exp_val = val;
    exp_req = 1'b1;
    do @(posedge clk); while (!exp_done);
    #2;
    exp_req = 1'b0;
  endtask

  task automatic run_op(input int i);
    case (op_kind[i])
      "W": write_reg(op_a[i][0], op_b[i]);
      "I": begin
        after_edge();
        irq_highest = op_a[i];
        isr_highest = op_b[i];
      end
      "A": inta_pair();
      "E": expect_value(op_a[i][3:0], op_b[i]);
      default: begin
        bad_ops++;
        $display("unknown operation in stimulus entry %0d", i);
      end
    endcase
  endtask

  initial begin
    rst_n       = 1'b0;
    wr          = 1'b0;
    a0          = 1'b0;
    din         = '0;
    inta_n      = 1'b1;
    irq_highest = '0;
    isr_highest = '0;
    mark        = 1'b0;
    exp_req     = 1'b0;
    exp_sig     = '0;
    exp_val     = '0;
    loaded      = 1'b0;
    bad_ops     = 0;
    load_stimulus();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    repeat (2) after_edge();
    total = errors + dut_i.chk_i.fail_count + bad_ops;
    if (n_ops == 0) begin
      $display("the stimulus file could not be read or holds no operations");
      total++;
    end
    $display("tests %0d, failed checks %0d, assertion failures %0d", tests, errors,
             dut_i.chk_i.fail_count);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog scaled by the number of operations
  initial begin
    wait (loaded);
    repeat ((n_ops + 1) * 200) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", (n_ops + 1) * 200);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/pic_cmd_pkg.sv ====
// PIC command word layout
`default_nettype none

package pic_cmd_pkg;

  // IR lines and vector base width
  parameter int IRQ_W      = 8;
  parameter int VEC_BASE_W = 5;

  // OCW2 R/SL/EOI codes that end a service
  parameter logic [2:0] OCW2_NS_EOI = 3'b001;
  parameter logic [2:0] OCW2_SP_EOI = 3'b011;

  typedef struct packed {
    logic [2:0] addr_hi;  // A7..A5, 8080 only
    logic       marker;
    logic       ltim;
    logic       adi;
    logic       sngl;
    logic       ic4;
  } icw1_t;

  typedef struct packed {
    logic [5:0] mode;     // SFNM, BUF, M/S and zero bits
    logic       aeoi;
    logic       upm;
  } icw4_t;

  typedef struct packed {
    logic [2:0] op;
    logic [1:0] zero;
    logic [2:0] level;
  } ocw2_t;

  typedef struct packed {
    logic [3:0] smm;      // ESMM, SMM and zero bits
    logic       marker;
    logic       poll;
    logic       rr;
    logic       ris;
  } ocw3_t;

  // one written byte, decoded by the state it arrives in
  typedef union packed {
    icw1_t icw1;
    icw4_t icw4;
    ocw2_t ocw2;
    ocw3_t ocw3;
  } cmd_word_u;

endpackage

`default_nettype wire

// ==== verilog/pic_control_top.sv ====
// PIC control core top
`timescale 1ns/1ps
`default_nettype none

module pic_control_top
  import pic_cmd_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr,
  input  logic             a0,
  input  logic [7:0]       din,
  input  logic             inta_n,
  input  logic [IRQ_W-1:0] irq_highest,
  input  logic [IRQ_W-1:0] isr_highest,
  output logic             int_req,
  output logic             set_isr,
  output logic [IRQ_W-1:0] clear_irr,
  output logic [IRQ_W-1:0] eoi,
  output logic [7:0]       vector,
  output logic             vector_valid,
  output logic             ltim,
  output logic             read_req,
  output logic             read_isr,
  output logic             init_done
);

  logic                  icw1_wr;
  logic                  ocw2_wr;
  logic                  ocw3_wr;
  logic [VEC_BASE_W-1:0] vector_base;
  logic                  aeoi;
  logic [IRQ_W-1:0]      in_service;
  logic                  ack_done;

  pic_init_ctrl u_init_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr          (wr),
    .a0          (a0),
    .din         (din),
    .icw1_wr     (icw1_wr),
    .ocw2_wr     (ocw2_wr),
    .ocw3_wr     (ocw3_wr),
    .vector_base (vector_base),
    .aeoi        (aeoi),
    .ltim        (ltim),
    .init_done   (init_done)
  );

  pic_inta_seq #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_inta_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .inta_n       (inta_n),
    .icw1_wr      (icw1_wr),
    .init_done    (init_done),
    .irq_highest  (irq_highest),
    .vector_base  (vector_base),
    .int_req      (int_req),
    .set_isr      (set_isr),
    .clear_irr    (clear_irr),
    .in_service   (in_service),
    .ack_done     (ack_done),
    .vector       (vector),
    .vector_valid (vector_valid)
  );

  pic_ocw_ctrl u_ocw_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .din         (din),
    .icw1_wr     (icw1_wr),
    .ocw2_wr     (ocw2_wr),
    .ocw3_wr     (ocw3_wr),
    .aeoi        (aeoi),
    .ack_done    (ack_done),
    .in_service  (in_service),
    .isr_highest (isr_highest),
    .eoi         (eoi),
    .read_req    (read_req),
    .read_isr    (read_isr)
  );

endmodule

`default_nettype wire

// ==== verilog/pic_init_ctrl.sv ====
// ICW sequence controller
`timescale 1ns/1ps
`default_nettype none

module pic_init_ctrl
  import pic_cmd_pkg::*, pic_seq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  logic                  a0,
  input  cmd_word_u             din,
  output logic                  icw1_wr,
  output logic                  ocw2_wr,
  output logic                  ocw3_wr,
  output logic [VEC_BASE_W-1:0] vector_base,
  output logic                  aeoi,
  output logic                  ltim,
  output logic                  init_done
);

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       sngl_q;
  logic       ic4_q;
  logic       icw2_wr;
  logic       icw3_wr;
  logic       icw4_wr;
  logic       ocw_wr;

  // ICW1 restarts the sequence from any state
  assign icw1_wr = wr & ~a0 & din.icw1.marker;

  // a0 high bytes outside their own state are OCW1 and dropped here
  assign icw2_wr = wr & a0 & (state_q == INIT_ICW2);
  assign icw3_wr = wr & a0 & (state_q == INIT_ICW3);
  assign icw4_wr = wr & a0 & (state_q == INIT_ICW4);

  // D3 splits OCW2 from OCW3
  assign ocw_wr  = wr & ~a0 & ~din.icw1.marker & (state_q == INIT_READY);
  assign ocw2_wr = ocw_wr & ~din.ocw3.marker;
  assign ocw3_wr = ocw_wr & din.ocw3.marker;

  assign init_done = (state_q == INIT_READY);

  always_comb begin
    state_d = state_q;
    if (icw1_wr) begin
      state_d = INIT_ICW2;
    end else begin
      case (state_q)
        INIT_ICW2: begin
          if (icw2_wr) begin
            if (!sngl_q) begin
              state_d = INIT_ICW3;
            end else begin
              state_d = ic4_q ? INIT_ICW4 : INIT_READY;
            end
          end
        end
        // cascade byte is consumed but not kept
        INIT_ICW3: begin
          if (icw3_wr) begin
            state_d = ic4_q ? INIT_ICW4 : INIT_READY;
          end
        end
        INIT_ICW4: begin
          if (icw4_wr) begin
            state_d = INIT_READY;
          end
        end
        default: state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= INIT_WAIT_ICW1;
      ltim        <= 1'b0;
      sngl_q      <= 1'b0;
      ic4_q       <= 1'b0;
      aeoi        <= 1'b0;
      vector_base <= '0;
    end else begin
      state_q <= state_d;
      if (icw1_wr) begin
        ltim   <= din.icw1.ltim;
        sngl_q <= din.icw1.sngl;
        ic4_q  <= din.icw1.ic4;
        aeoi   <= 1'b0;
      end
      // T7..T3
      if (icw2_wr) begin
        vector_base <= din[7 -: VEC_BASE_W];
      end
      if (icw4_wr) begin
        aeoi <= din.icw4.aeoi;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pic_inta_seq.sv ====
// Interrupt acknowledge sequencer
`timescale 1ns/1ps
`default_nettype none

module pic_inta_seq
  import pic_cmd_pkg::*, pic_seq_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inta_n,
  input  logic                  icw1_wr,
  input  logic                  init_done,
  input  logic [IRQ_W-1:0]      irq_highest,
  input  logic [VEC_BASE_W-1:0] vector_base,
  output logic                  int_req,
  output logic                  set_isr,
  output logic [IRQ_W-1:0]      clear_irr,
  output logic [IRQ_W-1:0]      in_service,
  output logic                  ack_done,
  output logic [7:0]            vector,
  output logic                  vector_valid
);

  localparam int IDX_W = $clog2(IRQ_W);

  logic [SYNC_STAGES-1:0] inta_sync;
  logic                   inta_s;
  logic                   inta_prev;
  logic                   inta_fall;
  logic                   inta_rise;
  logic                   take_first;
  logic                   take_second;
  logic [1:0]             ack_state;

  // lowest set bit wins
  function automatic logic [IDX_W-1:0] lowest_index(input logic [IRQ_W-1:0] bits);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = IRQ_W - 1; i >= 0; i--) begin
      if (bits[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inta_sync <= {SYNC_STAGES{INTA_IDLE}};
      inta_prev <= INTA_IDLE;
    end else begin
      inta_sync[0] <= inta_n;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        inta_sync[i] <= inta_sync[i-1];
      end
      inta_prev <= inta_s;
    end
  end

  assign inta_s    = inta_sync[SYNC_STAGES-1];
  assign inta_fall = inta_prev & ~inta_s;
  assign inta_rise = ~inta_prev & inta_s;

  assign int_req     = init_done & (ack_state == ACK_IDLE) & (|irq_highest);
  assign take_first  = inta_fall & int_req;
  assign take_second = inta_fall & (ack_state == ACK_FIRST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_state    <= ACK_IDLE;
      set_isr      <= 1'b0;
      clear_irr    <= '0;
      ack_done     <= 1'b0;
      vector_valid <= 1'b0;
    end else begin
      set_isr   <= 1'b0;
      clear_irr <= '0;
      ack_done  <= 1'b0;
      if (icw1_wr) begin
        ack_state    <= ACK_IDLE;
        vector_valid <= 1'b0;
      end else if (take_first) begin
        ack_state <= ACK_FIRST;
        set_isr   <= 1'b1;
        clear_irr <= irq_highest;
      end else if (take_second) begin
        ack_state    <= ACK_SECOND;
        vector_valid <= 1'b1;
      end else if (inta_rise && ack_state == ACK_SECOND) begin
        // sequence ends when the second pulse is released
        ack_state    <= ACK_IDLE;
        vector_valid <= 1'b0;
        ack_done     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_first) begin
      in_service <= irq_highest;
    end
    if (take_second) begin
      vector <= {vector_base, lowest_index(in_service)};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pic_ocw_ctrl.sv ====
// EOI and read select control
`timescale 1ns/1ps
`default_nettype none

module pic_ocw_ctrl
  import pic_cmd_pkg::*, pic_seq_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  cmd_word_u        din,
  input  logic             icw1_wr,
  input  logic             ocw2_wr,
  input  logic             ocw3_wr,
  input  logic             aeoi,
  input  logic             ack_done,
  input  logic [IRQ_W-1:0] in_service,
  input  logic [IRQ_W-1:0] isr_highest,
  output logic [IRQ_W-1:0] eoi,
  output logic             read_req,
  output logic             read_isr
);

  logic [IRQ_W-1:0] auto_mask;
  logic [IRQ_W-1:0] ocw2_mask;
  logic [IRQ_W-1:0] eoi_d;

  assign auto_mask = (ack_done && aeoi) ? in_service : '0;

  always_comb begin
    ocw2_mask = '0;
    if (ocw2_wr) begin
      case (din.ocw2.op)
        OCW2_NS_EOI: ocw2_mask = isr_highest;
        OCW2_SP_EOI: ocw2_mask = IRQ_W'(1) << din.ocw2.level;
        default:     ocw2_mask = '0;
      endcase
    end
  end

  // ICW1 wipes every in-service bit
  assign eoi_d = icw1_wr ? EOI_ALL : (auto_mask | ocw2_mask);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      eoi      <= '0;
      read_req <= 1'b0;
      read_isr <= 1'b0;
    end else begin
      eoi <= eoi_d;
      if (icw1_wr) begin
        read_req <= 1'b0;
        read_isr <= 1'b0;
      end else if (ocw3_wr) begin
        read_req <= din.ocw3.rr;
        read_isr <= din.ocw3.ris;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pic_seq_pkg.sv ====
// PIC sequence state codes
`default_nettype none

package pic_seq_pkg;

  // init sequence
  parameter logic [2:0] INIT_WAIT_ICW1 = 3'd0;
  parameter logic [2:0] INIT_ICW2      = 3'd1;
  parameter logic [2:0] INIT_ICW3      = 3'd2;
  parameter logic [2:0] INIT_ICW4      = 3'd3;
  parameter logic [2:0] INIT_READY     = 3'd4;

  // acknowledge sequence
  parameter logic [1:0] ACK_IDLE   = 2'd0;
  parameter logic [1:0] ACK_FIRST  = 2'd1;
  parameter logic [1:0] ACK_SECOND = 2'd2;

  // reset values
  parameter logic       INTA_IDLE = 1'b1;
  parameter logic [7:0] EOI_ALL   = 8'hff;

endpackage

`default_nettype wire
